//--- mem_request_pkg.sv
`default_nettype none

package mem_request_pkg;

    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 8;

    typedef enum logic
    {
        op_read  = 1'b0,
        op_write = 1'b1
    } mem_op_t;

    // op sits in the top bit, write data in the low word
    typedef struct packed
    {
        mem_op_t                 op;
        logic [ADDR_WIDTH-1:0]   addr;
        logic [DATA_WIDTH-1:0]   data;    // ignored on reads
    } mem_request_t;

    localparam int REQUEST_WIDTH = $bits(mem_request_t);

endpackage

`default_nettype wire

//--- arbiter_params_pkg.sv
`default_nettype none

package arbiter_params_pkg;

    localparam int NUM_REQUEST = 3;
    localparam int QUEUE_SIZE  = 4;    // power of two
    localparam int MEM_DEPTH   = 256;

    // at least one bit, even for a single requester
    function automatic int index_width(input int num_request);
        if (num_request > 1)
        begin
            return $clog2(num_request);
        end
        return 1;
    endfunction

endpackage

`default_nettype wire

//--- request_channel_if.sv
`timescale 1ns/10ps
`default_nettype none

interface request_channel_if;
    import mem_request_pkg::*;

    mem_request_t   request;
    logic           valid;
    logic           critical;    // also set by the queue when it is full
    logic           ack;

    modport queue_side
    (
        output request,
        output valid,
        output critical,
        input  ack
    );

    modport arbiter_side
    (
        input  request,
        input  valid,
        input  critical,
        output ack
    );

endinterface

`default_nettype wire

//--- fifo_queue.sv
`timescale 1ns/10ps
`default_nettype none

module fifo_queue
#(
    parameter int QUEUE_SIZE = arbiter_params_pkg::QUEUE_SIZE    // power of two
)
(
    input  wire logic                          clk_in,
    input  wire logic                          reset_in,

    input  wire mem_request_pkg::mem_request_t request_in,
    input  wire logic                          request_valid_in,
    input  wire logic                          request_critical_in,
    output logic                               issue_ack_out,
    output logic                               is_full_out,

    request_channel_if.queue_side              head
);
    import mem_request_pkg::*;

    localparam int PTR_WIDTH = $clog2(QUEUE_SIZE);

    mem_request_t           entry_request [QUEUE_SIZE];
    logic                   entry_critical [QUEUE_SIZE];

    // extra top bit tells full from empty
    logic [PTR_WIDTH:0]     wr_ptr;
    logic [PTR_WIDTH:0]     rd_ptr;

    logic                   full;
    logic                   empty;
    logic                   push;
    logic                   pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_WIDTH] != rd_ptr[PTR_WIDTH]) &&
                   (wr_ptr[PTR_WIDTH-1:0] == rd_ptr[PTR_WIDTH-1:0]);

    assign push = request_valid_in & ~full;
    assign pop  = head.valid & head.ack;

    assign issue_ack_out = ~full;
    assign is_full_out   = full;

    assign head.request  = entry_request[rd_ptr[PTR_WIDTH-1:0]];
    assign head.valid    = ~empty;
    assign head.critical = entry_critical[rd_ptr[PTR_WIDTH-1:0]] | full;   // full queue gets promoted

    always_ff @(posedge clk_in)
    begin
        if (push)
        begin
            entry_request[wr_ptr[PTR_WIDTH-1:0]]  <= request_in;
            entry_critical[wr_ptr[PTR_WIDTH-1:0]] <= request_critical_in;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- priority_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module priority_arbiter
#(
    parameter int  NUM_REQUEST = arbiter_params_pkg::NUM_REQUEST,
    localparam int ID_WIDTH    = arbiter_params_pkg::index_width(NUM_REQUEST)
)
(
    input  wire logic                      clk_in,
    input  wire logic                      reset_in,

    request_channel_if.arbiter_side        channels [NUM_REQUEST],

    output mem_request_pkg::mem_request_t  request_out,
    output logic [ID_WIDTH-1:0]            request_id_out,
    output logic                           request_valid_out,
    input  wire logic                      issue_ack_in
);
    import mem_request_pkg::*;

    mem_request_t              head_request [NUM_REQUEST];
    logic [NUM_REQUEST-1:0]    head_valid;
    logic [NUM_REQUEST-1:0]    head_critical;
    logic [NUM_REQUEST-1:0]    eligible;

    // vectors rotated so that bit 0 is the queue after the last one sent
    logic [NUM_REQUEST-1:0]    rot_valid;
    logic [NUM_REQUEST-1:0]    rot_critical;
    logic [ID_WIDTH-1:0]       rot_index [NUM_REQUEST];

    logic [ID_WIDTH-1:0]       last_send_index;
    logic [ID_WIDTH-1:0]       critical_sel;
    logic [ID_WIDTH-1:0]       valid_sel;
    logic [ID_WIDTH-1:0]       winner_sel;
    logic                      critical_found;
    logic                      valid_found;
    logic                      winner_found;
    logic                      load_en;

    function automatic logic [ID_WIDTH-1:0] wrap_index(input int position);
        if (position >= NUM_REQUEST)
        begin
            return ID_WIDTH'(position - NUM_REQUEST);
        end
        return ID_WIDTH'(position);
    endfunction

    for (genvar i = 0; i < NUM_REQUEST; i++)
    begin : g_channel
        assign head_request[i]  = channels[i].request;
        assign head_valid[i]    = channels[i].valid;
        assign head_critical[i] = channels[i].critical;

        // pop the queue whose request the memory takes now
        assign channels[i].ack  = issue_ack_in & request_valid_out &
                                  (last_send_index == ID_WIDTH'(i));

        assign rot_index[i]     = wrap_index(int'(last_send_index) + 1 + i);
        assign rot_valid[i]     = eligible[rot_index[i]];
        assign rot_critical[i]  = head_critical[rot_index[i]];
    end

    // the queue being acked still shows its old head this cycle
    always_comb
    begin
        eligible = head_valid;
        if (request_valid_out)
        begin
            eligible[last_send_index] = 1'b0;
        end
    end

    always_comb
    begin
        critical_found = 1'b0;
        valid_found    = 1'b0;
        critical_sel   = '0;
        valid_sel      = '0;
        for (int k = 0; k < NUM_REQUEST; k++)
        begin
            if (!critical_found && rot_valid[k] && rot_critical[k])
            begin
                critical_found = 1'b1;
                critical_sel   = rot_index[k];
            end
            if (!valid_found && rot_valid[k])
            begin
                valid_found = 1'b1;
                valid_sel   = rot_index[k];
            end
        end
    end

    assign winner_found = critical_found | valid_found;
    assign winner_sel   = critical_found ? critical_sel : valid_sel;
    assign load_en      = ~request_valid_out | issue_ack_in;    // empty or leaving now

    assign request_id_out = last_send_index;

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            request_valid_out <= 1'b0;
            last_send_index   <= '0;
        end
        else if (load_en)
        begin
            request_valid_out <= winner_found;
            if (winner_found)
            begin
                last_send_index <= winner_sel;
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (load_en && winner_found)
        begin
            request_out <= head_request[winner_sel];
        end
    end

endmodule

`default_nettype wire

//--- request_memory.sv
`timescale 1ns/10ps
`default_nettype none

module request_memory
#(
    parameter int  MEM_DEPTH      = arbiter_params_pkg::MEM_DEPTH,
    parameter int  NUM_REQUEST    = arbiter_params_pkg::NUM_REQUEST,
    localparam int ID_WIDTH       = arbiter_params_pkg::index_width(NUM_REQUEST),
    localparam int MEM_ADDR_WIDTH = $clog2(MEM_DEPTH)
)
(
    input  wire logic                              clk_in,
    input  wire logic                              reset_in,

    input  wire mem_request_pkg::mem_request_t     request_in,
    input  wire logic [ID_WIDTH-1:0]               request_id_in,
    input  wire logic                              request_valid_in,
    output logic                                   issue_ack_out,

    output logic                                   response_valid,
    output logic [mem_request_pkg::DATA_WIDTH-1:0] response_data,
    output logic [ID_WIDTH-1:0]                    response_id
);
    import mem_request_pkg::*;

    logic [DATA_WIDTH-1:0]      mem_array [MEM_DEPTH];
    logic                       read_busy;      // idle or waiting on a read
    logic [MEM_ADDR_WIDTH-1:0]  pending_addr;
    logic [ID_WIDTH-1:0]        pending_id;
    logic                       accept;
    logic                       accept_read;

    assign issue_ack_out = ~read_busy;
    assign accept        = request_valid_in & ~read_busy;
    assign accept_read   = accept & (request_in.op == op_read);

    always_ff @(posedge clk_in)
    begin
        if (accept && request_in.op == op_write)
        begin
            mem_array[request_in.addr[MEM_ADDR_WIDTH-1:0]] <= request_in.data;
        end
        if (accept_read)
        begin
            pending_addr <= request_in.addr[MEM_ADDR_WIDTH-1:0];
            pending_id   <= request_id_in;
        end
        if (read_busy)
        begin
            response_data <= mem_array[pending_addr];
            response_id   <= pending_id;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            read_busy      <= 1'b0;
            response_valid <= 1'b0;
        end
        else
        begin
            read_busy      <= accept_read;    // never accepts while busy
            response_valid <= read_busy;      // one-cycle strobe
        end
    end

endmodule

`default_nettype wire

//--- mem_arbiter_top.sv
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter_top
#(
    parameter int NUM_REQUEST = arbiter_params_pkg::NUM_REQUEST,
    parameter int QUEUE_SIZE  = arbiter_params_pkg::QUEUE_SIZE
)
(
    input  wire logic                                              clk_in,
    input  wire logic                                              reset_in,

    input  wire logic [NUM_REQUEST*mem_request_pkg::REQUEST_WIDTH-1:0] request_flat,
    input  wire logic [NUM_REQUEST-1:0]                            request_valid,
    input  wire logic [NUM_REQUEST-1:0]                            request_critical,
    output logic [NUM_REQUEST-1:0]                                 issue_ack,

    output logic                                                   response_valid,
    output logic [mem_request_pkg::DATA_WIDTH-1:0]                 response_data,
    output logic [arbiter_params_pkg::index_width(NUM_REQUEST)-1:0] response_id
);
    import mem_request_pkg::*;
    import arbiter_params_pkg::*;

    localparam int ID_WIDTH = index_width(NUM_REQUEST);

    request_channel_if channels [NUM_REQUEST] ();

    mem_request_t           arb_request;
    logic [ID_WIDTH-1:0]    arb_request_id;
    logic                   arb_request_valid;
    logic                   mem_ack;

    for (genvar i = 0; i < NUM_REQUEST; i++)
    begin : g_queue
        fifo_queue
        #(
            .QUEUE_SIZE          (QUEUE_SIZE)
        )
        u_queue
        (
            .clk_in              (clk_in),
            .reset_in            (reset_in),
            .request_in          (request_flat[i*REQUEST_WIDTH +: REQUEST_WIDTH]),
            .request_valid_in    (request_valid[i]),
            .request_critical_in (request_critical[i]),
            .issue_ack_out       (issue_ack[i]),
            .is_full_out         (),    // promotion is carried on the head critical bit
            .head                (channels[i])
        );
    end

    priority_arbiter
    #(
        .NUM_REQUEST       (NUM_REQUEST)
    )
    u_arbiter
    (
        .clk_in            (clk_in),
        .reset_in          (reset_in),
        .channels          (channels),
        .request_out       (arb_request),
        .request_id_out    (arb_request_id),
        .request_valid_out (arb_request_valid),
        .issue_ack_in      (mem_ack)
    );

    request_memory
    #(
        .MEM_DEPTH         (MEM_DEPTH),
        .NUM_REQUEST       (NUM_REQUEST)
    )
    u_memory
    (
        .clk_in            (clk_in),
        .reset_in          (reset_in),
        .request_in        (arb_request),
        .request_id_in     (arb_request_id),
        .request_valid_in  (arb_request_valid),
        .issue_ack_out     (mem_ack),
        .response_valid    (response_valid),
        .response_data     (response_data),
        .response_id       (response_id)
    );

endmodule

`default_nettype wire

//--- tb_mem_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mem_arbiter;
    import mem_request_pkg::*;
    import arbiter_params_pkg::*;

    localparam int ID_WIDTH       = index_width(NUM_REQUEST);
    localparam int TOTAL_REQUESTS = 12 + 6 + 9 + 3 + 14 + 24;    // worst case over all tests
    localparam int DRAIN_LIMIT    = 200;

    typedef struct packed
    {
        logic [ID_WIDTH-1:0]   id;
        logic [DATA_WIDTH-1:0] data;
    } expect_t;

    logic                                   clk_in;
    logic                                   reset_in;
    logic [NUM_REQUEST*REQUEST_WIDTH-1:0]   request_flat;
    logic [NUM_REQUEST-1:0]                 request_valid;
    logic [NUM_REQUEST-1:0]                 request_critical;
    logic [NUM_REQUEST-1:0]                 issue_ack;
    logic                                   response_valid;
    logic [DATA_WIDTH-1:0]                  response_data;
    logic [ID_WIDTH-1:0]                    response_id;

    logic [DATA_WIDTH-1:0]  model_mem [MEM_DEPTH];
    bit                     model_known [MEM_DEPTH];
    expect_t                pending [$];          // outstanding reads in issue order
    int                     response_log [$];
    logic [NUM_REQUEST-1:0] saw_full;
    string                  current_test;
    int                     seed = 12764;
    int                     error_count;
    int                     test_errors;
    int                     pass_count;
    int                     fail_count;

    mem_arbiter_top
    #(
        .NUM_REQUEST      (NUM_REQUEST),
        .QUEUE_SIZE       (QUEUE_SIZE)
    )
    u_dut
    (
        .clk_in           (clk_in),
        .reset_in         (reset_in),
        .request_flat     (request_flat),
        .request_valid    (request_valid),
        .request_critical (request_critical),
        .issue_ack        (issue_ack),
        .response_valid   (response_valid),
        .response_data    (response_data),
        .response_id      (response_id)
    );

    always #2 clk_in = ~clk_in;

    // reads are at least two cycles apart so the strobe never lasts longer
    assert property (@(posedge clk_in) disable iff (reset_in) response_valid |=> !response_valid)
    else
    begin
        $display("response_valid stayed high for more than one cycle");
        error_count++;
    end

    assert property (@(posedge clk_in) disable iff (reset_in)
                     !response_valid || response_id < ID_WIDTH'(NUM_REQUEST))
    else
    begin
        $display("response_id points at a requester that does not exist");
        error_count++;
    end

    function automatic mem_request_t make_request(input mem_op_t op, input logic [7:0] addr,
                                                  input logic [DATA_WIDTH-1:0] data);
        mem_request_t req;
        req.op   = op;
        req.addr = addr;
        req.data = data;
        return req;
    endfunction

    // each requester owns 16 words starting at 16*r
    function automatic logic [7:0] region_addr(input int r, input int k);
        return 8'(r * 16 + k);
    endfunction

    task automatic push_request(input int r, input mem_request_t req, input logic crit);
        expect_t e;
        request_flat[r*REQUEST_WIDTH +: REQUEST_WIDTH] = req;
        request_valid[r]    = 1'b1;
        request_critical[r] = crit;
        while (!issue_ack[r])
        begin
            saw_full[r] = 1'b1;
            @(negedge clk_in);
        end
        // taken by the queue at the coming rising edge
        if (req.op == op_write)
        begin
            model_mem[req.addr]   = req.data;
            model_known[req.addr] = 1'b1;
        end
        else
        begin
            e.id   = ID_WIDTH'(r);
            e.data = model_mem[req.addr];
            pending.push_back(e);
        end
        @(negedge clk_in);
        request_valid[r]    = 1'b0;
        request_critical[r] = 1'b0;
    endtask

    task automatic feed_reads(input int r, input int count);
        for (int k = 0; k < count; k++)
        begin
            push_request(r, make_request(op_read, region_addr(r, k % 4), '0), 1'b0);
        end
    endtask

    task automatic wait_responses();
        int cycles;
        cycles = 0;
        while (pending.size() > 0 && cycles < DRAIN_LIMIT)
        begin
            @(negedge clk_in);
            cycles++;
        end
        assert (pending.size() == 0)
        else
        begin
            $display("[%s] %0d read responses never arrived", current_test, pending.size());
            error_count++;
            pending.delete();
        end
    endtask

    task automatic begin_test(input string name);
        current_test = name;
        test_errors  = error_count;
        response_log.delete();
    endtask

    task automatic end_test();
        if (error_count == test_errors)
        begin
            $display("%s: passed", current_test);
            pass_count++;
        end
        else
        begin
            $display("%s: failed", current_test);
            fail_count++;
        end
    endtask

    // match each response with the oldest outstanding read of its requester
    always @(negedge clk_in)
    begin
        int found;
        found = -1;
        if (!reset_in && response_valid)
        begin
            response_log.push_back(int'(response_id));
            for (int i = 0; i < pending.size(); i++)
            begin
                if (found < 0 && pending[i].id == response_id)
                begin
                    found = i;
                end
            end
            assert (found >= 0)
            else
            begin
                $display("[%s] response for requester %0d with no read outstanding",
                         current_test, response_id);
                error_count++;
            end
            if (found >= 0)
            begin
                assert (response_data == pending[found].data)
                else
                begin
                    $display("** Error [%s] requester %0d read data: expected %h, actual %h",
                             current_test, response_id, pending[found].data, response_data);
                    error_count++;
                end
                pending.delete(found);
            end
        end
    end

    initial
    begin
        repeat (TOTAL_REQUESTS * 20) @(posedge clk_in);
        $display("watchdog expired before the tests finished");
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        int                    crit;
        int                    r;
        logic [7:0]            addr;
        logic [DATA_WIDTH-1:0] data;
        clk_in           = 1'b0;
        reset_in         = 1'b1;
        request_flat     = '0;
        request_valid    = '0;
        request_critical = '0;
        saw_full         = '0;
        repeat (2) @(negedge clk_in);
        reset_in = 1'b0;

        begin_test("reset_idle");
        assert (issue_ack == '1)
        else
        begin
            $display("** Error [%s] issue_ack: expected %b, actual %b", current_test,
                     {NUM_REQUEST{1'b1}}, issue_ack);
            error_count++;
        end
        for (int i = 0; i < 12; i++)    // preload four words per requester
        begin
            push_request(i / 4, make_request(op_write, region_addr(i / 4, i % 4),
                         $random(seed)), 1'b0);
        end
        repeat (8)
        begin
            @(negedge clk_in);
            assert (!response_valid)
            else
            begin
                $display("[%s] response_valid went high with no read issued", current_test);
                error_count++;
            end
        end
        end_test();

        begin_test("write_read");
        for (int i = 0; i < NUM_REQUEST; i++)
        begin
            response_log.delete();
            data = $random(seed);
            push_request(i, make_request(op_write, region_addr(i, 8), data), 1'b0);
            push_request(i, make_request(op_read, region_addr(i, 8), '0), 1'b0);
            wait_responses();
            assert (response_log.size() == 1 && response_log[0] == i)
            else
            begin
                $display("** Error [%s] response_id: expected %0d, actual %0d", current_test,
                         i, (response_log.size() > 0) ? response_log[0] : -1);
                error_count++;
            end
        end
        end_test();

        begin_test("fairness");
        fork
            feed_reads(0, 3);
            feed_reads(1, 3);
            feed_reads(2, 3);
        join
        wait_responses();
        for (int i = 0; i + 2 < response_log.size(); i++)
        begin
            assert (response_log[i] != response_log[i+1] && response_log[i] != response_log[i+2]
                    && response_log[i+1] != response_log[i+2])
            else
            begin
                $display("** Error [%s] ids %0d..%0d: expected distinct, actual %0d %0d %0d",
                         current_test, i, i + 2, response_log[i], response_log[i+1],
                         response_log[i+2]);
                error_count++;
            end
        end
        // full rounds starting at requester 0 end on the last requester
        crit = NUM_REQUEST - 1;
        end_test();

        // the last one served would otherwise come last again
        begin_test("critical_first");
        fork
            push_request(0, make_request(op_read, region_addr(0, 1), '0), crit == 0);
            push_request(1, make_request(op_read, region_addr(1, 1), '0), crit == 1);
            push_request(2, make_request(op_read, region_addr(2, 1), '0), crit == 2);
        join
        wait_responses();
        assert (response_log.size() > 0 && response_log[0] == crit)
        else
        begin
            $display("** Error [%s] first response_id: expected %0d, actual %0d", current_test,
                     crit, (response_log.size() > 0) ? response_log[0] : -1);
            error_count++;
        end
        end_test();

        begin_test("backpressure_random");
        saw_full = '0;
        fork
            feed_reads(0, 10);
            feed_reads(1, 4);
        join
        wait_responses();
        assert (saw_full[0])
        else
        begin
            $display("[%s] issue_ack of requester 0 never dropped with a full queue",
                     current_test);
            error_count++;
        end
        for (int n = 0; n < 12; n++)    // one request in flight over shared addresses
        begin
            r    = $unsigned($random(seed)) % NUM_REQUEST;
            addr = 8'h40 + 8'($unsigned($random(seed)) % 8);
            data = $random(seed);
            if (($random(seed) & 1) != 0 || !model_known[addr])
            begin
                push_request(r, make_request(op_write, addr, data), 1'b0);
            end
            push_request(r, make_request(op_read, addr, '0), 1'b0);
            wait_responses();
        end
        end_test();

        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0 && error_count == 0)
        begin
            $display("TEST PASSED");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mem_arbiter.f
mem_request_pkg.sv
arbiter_params_pkg.sv
request_channel_if.sv
fifo_queue.sv
priority_arbiter.sv
request_memory.sv
mem_arbiter_top.sv
tb_mem_arbiter.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f mem_arbiter.f --top-module tb_mem_arbiter -o sim_mem_arbiter

output=$(./obj_dir/sim_mem_arbiter)
echo "$output"

if grep -qx "TEST PASSED" <<< "$output"
then
    exit 0
fi
exit 1
